//--- verilog/sd_cmd_pkg.sv
package sd_cmd_pkg;

    // command token geometry
    localparam int CMD_INDEX_W = 6;
    localparam int CMD_ARG_W   = 32;
    localparam int CRC7_W      = 7;
    localparam int CMD_FRAME_W = 48;
    localparam int CRC_SPAN_W  = 40;

    // sd clocks from end bit to response start bit
    localparam int RESP_TIMEOUT = 64;

    typedef logic [CMD_INDEX_W-1:0] cmd_index_t;
    typedef logic [CMD_ARG_W-1:0]   cmd_arg_t;
    typedef logic [CMD_FRAME_W-1:0] cmd_frame_t;

    // crc7 with x^7 + x^3 + 1, msb first
    function automatic logic [CRC7_W-1:0] crc7(input logic [CRC_SPAN_W-1:0] span);
        logic [CRC7_W-1:0] crc;
        logic              fb;
        crc = '0;
        for (int i = CRC_SPAN_W - 1; i >= 0; i--) begin
            fb  = crc[CRC7_W-1] ^ span[i];
            crc = {crc[CRC7_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

endpackage

//--- verilog/sd_clock_divider.sv
module sd_clock_divider #(
    parameter int CLK_DIV = 2
) (
    input  logic s00_axi_aclk_i,
    input  logic rst_n_i,
    output logic sd_clk_o,
    output logic sd_rise_o,
    output logic sd_fall_o
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             sd_clk_q;
    logic             toggle;

    // half period elapsed
    assign toggle = (cnt_q == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            cnt_q    <= '0;
            sd_clk_q <= 1'b0;
        end else if (toggle) begin
            cnt_q    <= '0;
            sd_clk_q <= ~sd_clk_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign sd_clk_o = sd_clk_q;

    // strobe sits in the cycle before the pin changes
    assign sd_rise_o = toggle & ~sd_clk_q;
    assign sd_fall_o = toggle & sd_clk_q;

    strobes_exclusive: assert property (
        @(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        !(sd_rise_o && sd_fall_o)
    );

endmodule

//--- verilog/sd_cmd_framer.sv
module sd_cmd_framer (
    input  logic                    s00_axi_aclk_i,
    input  logic                    rst_n_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    input  sd_cmd_pkg::cmd_index_t  cmd_index_i,
    input  sd_cmd_pkg::cmd_arg_t    cmd_arg_i,
    output logic                    frame_valid_o,
    input  logic                    frame_ready_i,
    output sd_cmd_pkg::cmd_frame_t  frame_o
);

    import sd_cmd_pkg::*;

    logic                   full_q;
    cmd_frame_t             frame_q;
    logic [CRC_SPAN_W-1:0]  span;
    logic [CRC7_W-1:0]      crc;

    // start bit 0, direction bit 1 (host to card)
    assign span = {1'b0, 1'b1, cmd_index_i, cmd_arg_i};
    assign crc  = crc7(span);

    // empty, or draining this cycle
    assign cmd_ready_o = !full_q || frame_ready_i;

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (cmd_valid_i && cmd_ready_o) begin
            full_q <= 1'b1;
        end else if (frame_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge s00_axi_aclk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            frame_q <= {span, crc, 1'b1};
        end
    end

    assign frame_valid_o = full_q;
    assign frame_o       = frame_q;

    frame_held_while_stalled: assert property (
        @(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        frame_valid_o && !frame_ready_i |=> frame_valid_o && $stable(frame_o)
    );

endmodule

//--- verilog/sd_cmd_serializer.sv
module sd_cmd_serializer (
    input  logic                    s00_axi_aclk_i,
    input  logic                    rst_n_i,
    input  logic                    sd_fall_i,
    input  logic                    frame_valid_i,
    output logic                    frame_ready_o,
    input  sd_cmd_pkg::cmd_frame_t  frame_i,
    output logic                    sd_cmd_o,
    output logic                    sd_cmd_oe_o,
    output logic                    listen_valid_o,
    input  logic                    listen_ready_i,
    output sd_cmd_pkg::cmd_index_t  listen_index_o
);

    import sd_cmd_pkg::*;

    localparam int BIT_W = $clog2(CMD_FRAME_W);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_FALL,
        S_SHIFT,
        S_HAND
    } state_t;

    state_t             state_q;
    cmd_frame_t         shift_q;
    cmd_index_t         index_q;
    logic [BIT_W-1:0]   bit_cnt_q;
    logic               cmd_q;
    logic               oe_q;

    // no new token while the response stage is busy
    assign frame_ready_o = (state_q == S_IDLE) && listen_ready_i;

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            bit_cnt_q <= '0;
            cmd_q     <= 1'b1;
            oe_q      <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (frame_valid_i && frame_ready_o) begin
                        state_q <= S_WAIT_FALL;
                    end
                end
                S_WAIT_FALL: begin
                    if (sd_fall_i) begin
                        cmd_q     <= shift_q[CMD_FRAME_W-1];
                        oe_q      <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (sd_fall_i) begin
                        if (bit_cnt_q == BIT_W'(CMD_FRAME_W - 1)) begin
                            // end bit period done, release the line
                            cmd_q   <= 1'b1;
                            oe_q    <= 1'b0;
                            state_q <= S_HAND;
                        end else begin
                            cmd_q     <= shift_q[CMD_FRAME_W-1];
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (listen_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // token shifter, msb first
    always_ff @(posedge s00_axi_aclk_i) begin
        if (state_q == S_IDLE && frame_valid_i && frame_ready_o) begin
            shift_q <= frame_i;
            index_q <= frame_i[CMD_FRAME_W-3 -: CMD_INDEX_W];
        end else if (sd_fall_i && (state_q == S_WAIT_FALL || state_q == S_SHIFT)) begin
            shift_q <= {shift_q[CMD_FRAME_W-2:0], 1'b0};
        end
    end

    assign sd_cmd_o       = cmd_q;
    assign sd_cmd_oe_o    = oe_q;
    assign listen_valid_o = (state_q == S_HAND);
    assign listen_index_o = index_q;

    bit_cnt_in_range: assert property (
        @(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        state_q == S_SHIFT |-> bit_cnt_q < BIT_W'(CMD_FRAME_W)
    );

endmodule

//--- verilog/sd_cmd_response_rx.sv
module sd_cmd_response_rx (
    input  logic                    s00_axi_aclk_i,
    input  logic                    rst_n_i,
    input  logic                    sd_rise_i,
    input  logic                    sd_cmd_i,
    input  logic                    listen_valid_i,
    output logic                    listen_ready_o,
    input  sd_cmd_pkg::cmd_index_t  listen_index_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output sd_cmd_pkg::cmd_arg_t    resp_arg_o,
    output logic                    resp_crc_ok_o,
    output logic                    resp_index_ok_o,
    output logic                    resp_timeout_o
);

    import sd_cmd_pkg::*;

    localparam int BIT_W = $clog2(CMD_FRAME_W);
    localparam int TMO_W = $clog2(RESP_TIMEOUT);

    typedef enum logic [2:0] {
        R_IDLE,
        R_WAIT,
        R_SHIFT,
        R_CHECK,
        R_DONE
    } state_t;

    state_t             state_q;
    cmd_frame_t         shift_q;
    cmd_index_t         index_q;
    logic [BIT_W-1:0]   bit_cnt_q;
    logic [TMO_W-1:0]   tmo_cnt_q;
    cmd_arg_t           arg_q;
    logic               crc_ok_q;
    logic               index_ok_q;
    logic               timeout_q;
    logic               got_timeout;

    assign got_timeout = (state_q == R_WAIT) && sd_rise_i && sd_cmd_i &&
                         (tmo_cnt_q == TMO_W'(RESP_TIMEOUT - 1));

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            state_q   <= R_IDLE;
            bit_cnt_q <= '0;
            tmo_cnt_q <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    if (listen_valid_i) begin
                        tmo_cnt_q <= '0;
                        state_q   <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (sd_rise_i) begin
                        if (!sd_cmd_i) begin
                            // start bit counts as the first bit
                            bit_cnt_q <= BIT_W'(1);
                            state_q   <= R_SHIFT;
                        end else if (got_timeout) begin
                            state_q <= R_DONE;
                        end else begin
                            tmo_cnt_q <= tmo_cnt_q + 1'b1;
                        end
                    end
                end
                R_SHIFT: begin
                    if (sd_rise_i) begin
                        if (bit_cnt_q == BIT_W'(CMD_FRAME_W - 1)) begin
                            state_q <= R_CHECK;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                R_CHECK: begin
                    state_q <= R_DONE;
                end
                default: begin
                    if (resp_ready_i) begin
                        state_q <= R_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge s00_axi_aclk_i) begin
        if (state_q == R_IDLE && listen_valid_i) begin
            index_q <= listen_index_i;
        end
        if (sd_rise_i && (state_q == R_WAIT || state_q == R_SHIFT)) begin
            shift_q <= {shift_q[CMD_FRAME_W-2:0], sd_cmd_i};
        end
    end

    // result registers
    always_ff @(posedge s00_axi_aclk_i) begin
        if (got_timeout) begin
            arg_q      <= '0;
            crc_ok_q   <= 1'b0;
            index_ok_q <= 1'b0;
            timeout_q  <= 1'b1;
        end else if (state_q == R_CHECK) begin
            arg_q      <= shift_q[CMD_FRAME_W-9 -: CMD_ARG_W];
            crc_ok_q   <= (crc7(shift_q[CMD_FRAME_W-1 -: CRC_SPAN_W]) == shift_q[CRC7_W:1]);
            index_ok_q <= (shift_q[CMD_FRAME_W-3 -: CMD_INDEX_W] == index_q);
            timeout_q  <= 1'b0;
        end
    end

    // busy from acceptance until the host takes the result
    assign listen_ready_o  = (state_q == R_IDLE);
    assign resp_valid_o    = (state_q == R_DONE);
    assign resp_arg_o      = arg_q;
    assign resp_crc_ok_o   = crc_ok_q;
    assign resp_index_ok_o = index_ok_q;
    assign resp_timeout_o  = timeout_q;

    result_held_while_stalled: assert property (
        @(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o &&
            $stable({resp_arg_o, resp_crc_ok_o, resp_index_ok_o, resp_timeout_o})
    );

endmodule

//--- verilog/sd_cmd_host.sv
module sd_cmd_host #(
    parameter int CLK_DIV = 2
) (
    input  logic                    s00_axi_aclk_i,
    input  logic                    rst_n_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    input  sd_cmd_pkg::cmd_index_t  cmd_index_i,
    input  sd_cmd_pkg::cmd_arg_t    cmd_arg_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output sd_cmd_pkg::cmd_arg_t    resp_arg_o,
    output logic                    resp_crc_ok_o,
    output logic                    resp_index_ok_o,
    output logic                    resp_timeout_o,
    output logic                    sd_clk_o,
    output logic                    sd_cmd_o,
    output logic                    sd_cmd_oe_o,
    input  logic                    sd_cmd_i
);

    import sd_cmd_pkg::*;

    logic       sd_rise;
    logic       sd_fall;
    logic       frame_valid;
    logic       frame_ready;
    cmd_frame_t frame_data;
    logic       listen_valid;
    logic       listen_ready;
    cmd_index_t listen_index;

    sd_clock_divider #(
        .CLK_DIV(CLK_DIV)
    ) sd_clock_divider_i (
        .s00_axi_aclk_i (s00_axi_aclk_i),
        .rst_n_i        (rst_n_i),
        .sd_clk_o       (sd_clk_o),
        .sd_rise_o      (sd_rise),
        .sd_fall_o      (sd_fall)
    );

    sd_cmd_framer sd_cmd_framer_i (
        .s00_axi_aclk_i (s00_axi_aclk_i),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .cmd_index_i    (cmd_index_i),
        .cmd_arg_i      (cmd_arg_i),
        .frame_valid_o  (frame_valid),
        .frame_ready_i  (frame_ready),
        .frame_o        (frame_data)
    );

    sd_cmd_serializer sd_cmd_serializer_i (
        .s00_axi_aclk_i (s00_axi_aclk_i),
        .rst_n_i        (rst_n_i),
        .sd_fall_i      (sd_fall),
        .frame_valid_i  (frame_valid),
        .frame_ready_o  (frame_ready),
        .frame_i        (frame_data),
        .sd_cmd_o       (sd_cmd_o),
        .sd_cmd_oe_o    (sd_cmd_oe_o),
        .listen_valid_o (listen_valid),
        .listen_ready_i (listen_ready),
        .listen_index_o (listen_index)
    );

    sd_cmd_response_rx sd_cmd_response_rx_i (
        .s00_axi_aclk_i  (s00_axi_aclk_i),
        .rst_n_i         (rst_n_i),
        .sd_rise_i       (sd_rise),
        .sd_cmd_i        (sd_cmd_i),
        .listen_valid_i  (listen_valid),
        .listen_ready_o  (listen_ready),
        .listen_index_i  (listen_index),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_arg_o      (resp_arg_o),
        .resp_crc_ok_o   (resp_crc_ok_o),
        .resp_index_ok_o (resp_index_ok_o),
        .resp_timeout_o  (resp_timeout_o)
    );

endmodule

//--- tests/sd_card_model.sv
module sd_card_model (
    input  logic                    sd_clk_i,
    input  logic                    host_cmd_i,
    input  logic                    host_oe_i,
    input  sd_cmd_pkg::cmd_frame_t  reply_i,
    input  logic                    silent_i,
    output logic                    line_o,
    output sd_cmd_pkg::cmd_frame_t  token_o,
    output int unsigned             tokens_o
);

    import sd_cmd_pkg::*;

    logic card_oe;
    logic card_bit;

    // pull-up when neither side drives the line
    assign line_o = (host_oe_i === 1'b1) ? host_cmd_i :
                    (card_oe ? card_bit : 1'b1);

    initial begin
        cmd_frame_t rx;
        cmd_frame_t reply;
        int         i;
        card_oe  = 1'b0;
        card_bit = 1'b1;
        token_o  = '0;
        tokens_o = 0;
        forever begin
            @(posedge sd_clk_i);
            // host has started driving, first bit is its start bit
            if (host_oe_i === 1'b1) begin
                rx = CMD_FRAME_W'(line_o);
                for (i = 1; i < CMD_FRAME_W; i++) begin
                    @(posedge sd_clk_i);
                    rx = {rx[CMD_FRAME_W-2:0], line_o};
                end
                token_o  = rx;
                tokens_o = tokens_o + 1;
                // turnaround gap before the reply
                repeat (8) @(negedge sd_clk_i);
                if (!silent_i) begin
                    reply = reply_i;
                    for (i = CMD_FRAME_W - 1; i >= 0; i--) begin
                        card_bit = reply[i];
                        card_oe  = 1'b1;
                        @(negedge sd_clk_i);
                    end
                    card_oe  = 1'b0;
                    card_bit = 1'b1;
                end
            end
        end
    end

endmodule

//--- tests/tb_sd_cmd_host.sv
module tb_sd_cmd_host;

    import sd_cmd_pkg::*;

    localparam int CLK_DIV   = 2;
    localparam int ROWS      = 8;
    localparam int MAX_STALL = 40;
    localparam int LIMIT     = ROWS * (CMD_FRAME_W + 8 + RESP_TIMEOUT + CMD_FRAME_W) *
                               2 * CLK_DIV * 2 + ROWS * MAX_STALL;

    // card reply modes
    localparam logic [1:0] MODE_OK        = 2'd0;
    localparam logic [1:0] MODE_BAD_CRC   = 2'd1;
    localparam logic [1:0] MODE_BAD_INDEX = 2'd2;
    localparam logic [1:0] MODE_SILENT    = 2'd3;

    // index, argument, reply mode, reply argument
    cmd_index_t tab_index [ROWS] = '{6'd0, 6'd17, 6'd8, 6'd55, 6'd13, 6'd2, 6'd63, 6'd7};
    cmd_arg_t   tab_arg   [ROWS] = '{32'h0000_0000, 32'h0000_0000, 32'h0000_01aa,
                                     32'h1234_0000, 32'h5678_0000, 32'h0000_0000,
                                     32'hffff_ffff, 32'ha5a5_0000};
    logic [1:0] tab_mode  [ROWS] = '{MODE_OK, MODE_OK, MODE_OK, MODE_BAD_CRC,
                                     MODE_BAD_INDEX, MODE_SILENT, MODE_BAD_INDEX, MODE_OK};
    cmd_arg_t   tab_reply [ROWS] = '{32'h0000_0120, 32'h0000_0900, 32'h0000_01aa,
                                     32'h0000_0120, 32'h0000_0900, 32'h0000_0000,
                                     32'hdead_beef, 32'h0000_0700};

    // names follow the DUT ports
    logic        s00_axi_aclk_i;
    logic        rst_n_i;
    logic        cmd_valid_i;
    logic        cmd_ready_o;
    cmd_index_t  cmd_index_i;
    cmd_arg_t    cmd_arg_i;
    logic        resp_valid_o;
    logic        resp_ready_i;
    cmd_arg_t    resp_arg_o;
    logic        resp_crc_ok_o;
    logic        resp_index_ok_o;
    logic        resp_timeout_o;
    logic        sd_clk_o;
    logic        sd_cmd_o;
    logic        sd_cmd_oe_o;
    logic        sd_cmd_i;
    cmd_frame_t  card_reply;
    logic        card_silent;
    cmd_frame_t  card_token;
    int unsigned card_tokens;
    int unsigned tokens_checked;
    logic        saw_backpressure;
    int          cycles = 0;

    initial begin
        s00_axi_aclk_i = 1'b0;
        forever #4 s00_axi_aclk_i = ~s00_axi_aclk_i;
    end

    sd_cmd_host #(
        .CLK_DIV(CLK_DIV)
    ) dut_i (.*);

    sd_card_model card_i (
        .sd_clk_i   (sd_clk_o),
        .host_cmd_i (sd_cmd_o),
        .host_oe_i  (sd_cmd_oe_o),
        .reply_i    (card_reply),
        .silent_i   (card_silent),
        .line_o     (sd_cmd_i),
        .token_o    (card_token),
        .tokens_o   (card_tokens)
    );

    // long division by x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] calc_crc7(input logic [CRC_SPAN_W-1:0] span);
        logic [CRC_SPAN_W+CRC7_W-1:0] rem;
        int                           i;
        rem = {span, 7'b0};
        for (i = CRC_SPAN_W + CRC7_W - 1; i >= CRC7_W; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[CRC7_W-1:0];
    endfunction

    function automatic cmd_frame_t build_reply(input int row);
        cmd_index_t            idx;
        logic [CRC_SPAN_W-1:0] span;
        logic [CRC7_W-1:0]     crc;
        idx = tab_index[row];
        if (tab_mode[row] == MODE_BAD_INDEX) begin
            idx = idx + 1'b1;
        end
        span = {2'b00, idx, tab_reply[row]};
        crc  = calc_crc7(span);
        if (tab_mode[row] == MODE_BAD_CRC) begin
            crc = ~crc;
        end
        return {span, crc, 1'b1};
    endfunction

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_token(input int row);
        check_equal("sd_cmd_o start bit", 64'(card_token[47]), 64'd0);
        check_equal("sd_cmd_o direction bit", 64'(card_token[46]), 64'd1);
        check_equal("sd_cmd_o index", 64'(card_token[45:40]), 64'(tab_index[row]));
        check_equal("sd_cmd_o argument", 64'(card_token[39:8]), 64'(tab_arg[row]));
        check_equal("sd_cmd_o crc7", 64'(card_token[7:1]), 64'(calc_crc7(card_token[47:8])));
        check_equal("sd_cmd_o end bit", 64'(card_token[0]), 64'd1);
    endtask

    task automatic check_result(input int row);
        logic silent;
        silent = (tab_mode[row] == MODE_SILENT);
        check_equal("resp_valid_o", 64'(resp_valid_o), 64'd1);
        check_equal("resp_timeout_o", 64'(resp_timeout_o), 64'(silent));
        check_equal("resp_arg_o", 64'(resp_arg_o), silent ? 64'd0 : 64'(tab_reply[row]));
        check_equal("resp_crc_ok_o", 64'(resp_crc_ok_o),
                    64'(tab_mode[row] == MODE_OK || tab_mode[row] == MODE_BAD_INDEX));
        check_equal("resp_index_ok_o", 64'(resp_index_ok_o),
                    64'(tab_mode[row] == MODE_OK || tab_mode[row] == MODE_BAD_CRC));
    endtask

    task automatic drive_commands();
        int row;
        for (row = 0; row < ROWS; row++) begin
            cmd_valid_i <= 1'b1;
            cmd_index_i <= tab_index[row];
            cmd_arg_i   <= tab_arg[row];
            @(posedge s00_axi_aclk_i);
            while (cmd_ready_o !== 1'b1) begin
                saw_backpressure = 1'b1;
                @(posedge s00_axi_aclk_i);
            end
        end
        cmd_valid_i <= 1'b0;
    endtask

    // results must come back in table order and hold while stalled
    task automatic collect_results();
        int row;
        int stall;
        int k;
        for (row = 0; row < ROWS; row++) begin
            stall = int'($urandom_range(MAX_STALL, 0));
            @(posedge s00_axi_aclk_i);
            while (resp_valid_o !== 1'b1) begin
                @(posedge s00_axi_aclk_i);
            end
            check_result(row);
            for (k = 0; k < stall; k++) begin
                @(posedge s00_axi_aclk_i);
                check_result(row);
            end
            resp_ready_i <= 1'b1;
            @(posedge s00_axi_aclk_i);
            check_result(row);
            resp_ready_i <= 1'b0;
        end
    endtask

    // checks each token the card saw and loads the matching reply
    initial begin
        card_reply     = '1;
        card_silent    = 1'b1;
        tokens_checked = 0;
        forever begin
            wait (card_tokens > tokens_checked);
            @(negedge s00_axi_aclk_i);
            if (tokens_checked >= ROWS) begin
                $display("an unexpected extra command token appeared on the cmd line");
                $display("** FAIL **");
                $fatal(1, "extra command token");
            end else begin
                check_token(tokens_checked);
                card_reply     = build_reply(tokens_checked);
                card_silent    = (tab_mode[tokens_checked] == MODE_SILENT);
                tokens_checked = tokens_checked + 1;
            end
        end
    end

    always @(posedge s00_axi_aclk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("the run timed out after %0d cycles without finishing", LIMIT);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(72915));
        rst_n_i          <= 1'b0;
        cmd_valid_i      <= 1'b0;
        cmd_index_i      <= '0;
        cmd_arg_i        <= '0;
        resp_ready_i     <= 1'b0;
        saw_backpressure = 1'b0;
        // known crc7 vectors
        check_equal("crc7 of CMD0", 64'(calc_crc7(40'h40_0000_0000)), 64'h4a);
        check_equal("crc7 of CMD17", 64'(calc_crc7(40'h51_0000_0000)), 64'h2a);
        check_equal("crc7 of CMD17 response", 64'(calc_crc7(40'h11_0000_0900)), 64'h33);
        repeat (10) @(posedge s00_axi_aclk_i);
        check_equal("cmd_ready_o", 64'(cmd_ready_o), 64'd1);
        check_equal("resp_valid_o", 64'(resp_valid_o), 64'd0);
        check_equal("sd_cmd_oe_o", 64'(sd_cmd_oe_o), 64'd0);
        check_equal("sd_cmd_o", 64'(sd_cmd_o), 64'd1);
        check_equal("sd_clk_o", 64'(sd_clk_o), 64'd0);
        rst_n_i <= 1'b1;
        fork
            drive_commands();
            collect_results();
        join
        repeat (50) @(posedge s00_axi_aclk_i);
        check_equal("resp_valid_o after last result", 64'(resp_valid_o), 64'd0);
        check_equal("tokens on cmd line", 64'(card_tokens), 64'(ROWS));
        check_equal("tokens checked", 64'(tokens_checked), 64'(ROWS));
        check_equal("cmd_ready_o low under back-pressure", 64'(saw_backpressure), 64'd1);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- src.f
verilog/sd_cmd_pkg.sv
verilog/sd_clock_divider.sv
verilog/sd_cmd_framer.sv
verilog/sd_cmd_serializer.sv
verilog/sd_cmd_response_rx.sv
verilog/sd_cmd_host.sv
tests/sd_card_model.sv
tests/tb_sd_cmd_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_sd_cmd_host \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_sd_cmd_host
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
